// ==== common/chip8_pkg.sv ====
// Shared widths, encodings and command structs for the CHIP-8 execution core
// Instruction fields follow the usual nibble layout, kk and nnn are the low 8/12 bits
package chip8_pkg;

	// Architectural widths
	parameter int ADDR_W = 12;
	parameter int DATA_W = 8;
	parameter int REG_CNT = 16;

	// VF carries carry, not-borrow and shifted-out bits
	parameter logic [3:0] FLAG_REG = 4'hF;

	// Programs start above the interpreter area
	parameter logic [ADDR_W-1:0] PC_RESET = 12'h200;

	// Bytes per hex font glyph
	parameter int FONT_STRIDE = 5;

	// Default return-stack size, power of two
	parameter int STACK_DEPTH = 16;

	// One instruction word, kk = {y, n}, nnn = {x, y, n}
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] x;
		logic [3:0] y;
		logic [3:0] n;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_ADD,
		ALU_SUB,
		ALU_SHR,
		ALU_SHL
	} alu_op_e;

	typedef enum logic [2:0] {
		PC_NEXT,
		PC_SKIP,
		PC_JUMP,
		PC_CALL,
		PC_RET
	} pc_src_e;

	// Register write port
	typedef struct packed {
		logic we;
		logic [3:0] idx;
		logic [DATA_W-1:0] data;
	} reg_wr_t;

	typedef struct packed {
		pc_src_e src;
		logic [ADDR_W-1:0] target;
	} pc_cmd_t;

	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] value;
	} i_wr_t;

endpackage

// ==== exec/chip8_alu.sv ====
// 8-bit ALU for the 8xy group and the immediate forms
// Flag is carry on add, not-borrow on sub, shifted-out bit on shifts, else 0
`timescale 1ns/1ps

module chip8_alu (
	input logic [chip8_pkg::DATA_W-1:0] a,
	input logic [chip8_pkg::DATA_W-1:0] b,
	input chip8_pkg::alu_op_e op,
	output logic [chip8_pkg::DATA_W-1:0] res,
	output logic flag
);

	logic [chip8_pkg::DATA_W:0] sum;

	// Extra bit holds the carry out
	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		res = b;
		flag = 1'b0;
		case (op)
			chip8_pkg::ALU_PASS: res = b;
			chip8_pkg::ALU_OR: res = a | b;
			chip8_pkg::ALU_AND: res = a & b;
			chip8_pkg::ALU_XOR: res = a ^ b;
			chip8_pkg::ALU_ADD: begin
				res = sum[chip8_pkg::DATA_W-1:0];
				flag = sum[chip8_pkg::DATA_W];
			end
			chip8_pkg::ALU_SUB: begin
				// Equal operands count as no borrow
				res = a - b;
				flag = (a >= b);
			end
			chip8_pkg::ALU_SHR: begin
				res = a >> 1;
				flag = a[0];
			end
			chip8_pkg::ALU_SHL: begin
				res = a << 1;
				flag = a[chip8_pkg::DATA_W-1];
			end
			default: ;
		endcase
	end

endmodule

// ==== exec/chip8_decode.sv ====
// Combinational decode of one latched instruction into register, I and PC commands
// Write enables are only raised while exec is high, unkept opcodes just advance PC
`timescale 1ns/1ps

module chip8_decode (
	input logic exec,
	input chip8_pkg::instr_t ins,
	output logic [3:0] rd_addr_a,
	output logic [3:0] rd_addr_b,
	input logic [chip8_pkg::DATA_W-1:0] rd_data_a,
	input logic [chip8_pkg::DATA_W-1:0] rd_data_b,
	input logic [chip8_pkg::ADDR_W-1:0] i_cur,
	output logic [chip8_pkg::DATA_W-1:0] alu_a,
	output logic [chip8_pkg::DATA_W-1:0] alu_b,
	output chip8_pkg::alu_op_e alu_op,
	input logic [chip8_pkg::DATA_W-1:0] alu_res,
	input logic alu_flag,
	output chip8_pkg::reg_wr_t wr_res,
	output chip8_pkg::reg_wr_t wr_flag,
	output chip8_pkg::i_wr_t i_wr,
	output chip8_pkg::pc_cmd_t pc_cmd
);

	logic [chip8_pkg::DATA_W-1:0] kk;
	logic [chip8_pkg::ADDR_W-1:0] nnn;
	logic res_en;
	logic flag_en;
	logic i_en;

	assign kk = {ins.y, ins.n};
	assign nnn = {ins.x, ins.y, ins.n};

	// Bnnn needs V0 on port A, everything else reads Vx there
	assign rd_addr_a = (ins.opcode == 4'hB) ? 4'h0 : ins.x;
	assign rd_addr_b = ins.y;

	always_comb begin
		alu_a = rd_data_a;
		alu_b = rd_data_b;
		alu_op = chip8_pkg::ALU_PASS;
		res_en = 1'b0;
		flag_en = 1'b0;
		i_en = 1'b0;
		i_wr.value = nnn;
		pc_cmd.src = chip8_pkg::PC_NEXT;
		pc_cmd.target = nnn;

		case (ins.opcode)
			// Only 00EE survives in the 0 group
			4'h0: if (ins == 16'h00EE) pc_cmd.src = chip8_pkg::PC_RET;
			4'h1: pc_cmd.src = chip8_pkg::PC_JUMP;
			4'h2: pc_cmd.src = chip8_pkg::PC_CALL;
			4'h3: if (rd_data_a == kk) pc_cmd.src = chip8_pkg::PC_SKIP;
			4'h4: if (rd_data_a != kk) pc_cmd.src = chip8_pkg::PC_SKIP;
			4'h5: begin
				if (ins.n == 4'h0 && rd_data_a == rd_data_b)
					pc_cmd.src = chip8_pkg::PC_SKIP;
			end
			4'h6: begin
				// Immediate load goes through ALU pass
				alu_b = kk;
				res_en = 1'b1;
			end
			4'h7: begin
				// Add immediate, VF untouched
				alu_b = kk;
				alu_op = chip8_pkg::ALU_ADD;
				res_en = 1'b1;
			end
			4'h8: begin
				res_en = 1'b1;
				flag_en = 1'b1;
				case (ins.n)
					4'h0: flag_en = 1'b0;
					4'h1: begin
						alu_op = chip8_pkg::ALU_OR;
						flag_en = 1'b0;
					end
					4'h2: begin
						alu_op = chip8_pkg::ALU_AND;
						flag_en = 1'b0;
					end
					4'h3: begin
						alu_op = chip8_pkg::ALU_XOR;
						flag_en = 1'b0;
					end
					4'h4: alu_op = chip8_pkg::ALU_ADD;
					4'h5: alu_op = chip8_pkg::ALU_SUB;
					4'h6: alu_op = chip8_pkg::ALU_SHR;
					4'h7: begin
						// SUBN swaps operands so the ALU always does a - b
						alu_a = rd_data_b;
						alu_b = rd_data_a;
						alu_op = chip8_pkg::ALU_SUB;
					end
					4'hE: alu_op = chip8_pkg::ALU_SHL;
					default: begin
						res_en = 1'b0;
						flag_en = 1'b0;
					end
				endcase
			end
			4'h9: begin
				if (ins.n == 4'h0 && rd_data_a != rd_data_b)
					pc_cmd.src = chip8_pkg::PC_SKIP;
			end
			4'hA: i_en = 1'b1;
			4'hB: begin
				pc_cmd.src = chip8_pkg::PC_JUMP;
				pc_cmd.target = nnn + chip8_pkg::ADDR_W'(rd_data_a);
			end
			4'hF: begin
				if (kk == 8'h1E) begin
					i_en = 1'b1;
					i_wr.value = i_cur + chip8_pkg::ADDR_W'(rd_data_a);
				end else if (kk == 8'h29) begin
					// Glyph address from the low nibble of Vx
					i_en = 1'b1;
					i_wr.value = chip8_pkg::ADDR_W'(rd_data_a[3:0] * chip8_pkg::FONT_STRIDE);
				end
			end
			default: ;
		endcase
	end

	// Result to Vx, flag to VF, reg_file gives VF priority on x == F
	assign wr_res = '{we: exec & res_en, idx: ins.x, data: alu_res};
	assign wr_flag = '{we: exec & flag_en, idx: chip8_pkg::FLAG_REG,
		data: chip8_pkg::DATA_W'(alu_flag)};
	assign i_wr.we = exec & i_en;

endmodule

// ==== pc/call_stack.sv ====
// Return-address stack, DEPTH must be a power of two and at least 2
// Pointer wraps silently, overflow overwrites the oldest entry
`timescale 1ns/1ps

module call_stack #(
	parameter int DEPTH = chip8_pkg::STACK_DEPTH
) (
	input logic cpu_clk,
	input logic rst_n,
	input logic push,
	input logic pop,
	input logic [chip8_pkg::ADDR_W-1:0] push_data,
	output logic [chip8_pkg::ADDR_W-1:0] top
);

	localparam int PTR_W = $clog2(DEPTH);

	logic [chip8_pkg::ADDR_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] sp;
	logic [PTR_W-1:0] sp_below;

	// Pointer names the next free slot
	assign sp_below = sp - PTR_W'(1);
	assign top = mem[sp_below];

	always_ff @(posedge cpu_clk) begin
		if (!rst_n)
			sp <= '0;
		else if (push)
			sp <= sp + PTR_W'(1);
		else if (pop)
			sp <= sp_below;
	end

	// Entries need no reset, sp decides what is valid
	always_ff @(posedge cpu_clk) begin
		if (push)
			mem[sp] <= push_data;
	end

endmodule

// ==== pc/pc_unit.sv ====
// Program counter with next, skip, jump, call and return selection
// Moves only on an exec cycle, all arithmetic wraps at 12 bits
`timescale 1ns/1ps

module pc_unit #(
	parameter int STACK_DEPTH = chip8_pkg::STACK_DEPTH
) (
	input logic cpu_clk,
	input logic rst_n,
	input logic exec,
	input chip8_pkg::pc_cmd_t pc_cmd,
	output logic [chip8_pkg::ADDR_W-1:0] pc
);

	logic [chip8_pkg::ADDR_W-1:0] pc_plus2;
	logic [chip8_pkg::ADDR_W-1:0] pc_plus4;
	logic [chip8_pkg::ADDR_W-1:0] pc_next;
	logic [chip8_pkg::ADDR_W-1:0] stack_top;
	logic push;
	logic pop;

	assign pc_plus2 = pc + chip8_pkg::ADDR_W'(2);
	assign pc_plus4 = pc + chip8_pkg::ADDR_W'(4);

	// Stack moves in the same cycle as the PC
	assign push = exec && (pc_cmd.src == chip8_pkg::PC_CALL);
	assign pop = exec && (pc_cmd.src == chip8_pkg::PC_RET);

	always_comb begin
		case (pc_cmd.src)
			chip8_pkg::PC_SKIP: pc_next = pc_plus4;
			chip8_pkg::PC_JUMP: pc_next = pc_cmd.target;
			chip8_pkg::PC_CALL: pc_next = pc_cmd.target;
			chip8_pkg::PC_RET: pc_next = stack_top;
			default: pc_next = pc_plus2;
		endcase
	end

	always_ff @(posedge cpu_clk) begin
		if (!rst_n)
			pc <= chip8_pkg::PC_RESET;
		else if (exec)
			pc <= pc_next;
	end

	// Return address is the instruction after the call
	call_stack #(.DEPTH(STACK_DEPTH)) stack_i (
		.cpu_clk(cpu_clk),
		.rst_n(rst_n),
		.push(push),
		.pop(pop),
		.push_data(pc_plus2),
		.top(stack_top)
	);

endmodule

// ==== src/chip8_core.sv ====
// CHIP-8 execution core, one instruction per strobe, two cycles each
// Strobes while busy are dropped, no memory, display, timers or keypad
`timescale 1ns/1ps

module chip8_core #(
	parameter int STACK_DEPTH = chip8_pkg::STACK_DEPTH
) (
	input logic cpu_clk,
	input logic rst_n,
	input logic instr_strobe,
	input chip8_pkg::instr_t instr,
	output logic busy,
	output logic [chip8_pkg::ADDR_W-1:0] pc,
	output logic [chip8_pkg::ADDR_W-1:0] i_reg,
	input logic [3:0] host_reg_addr,
	output logic [chip8_pkg::DATA_W-1:0] host_reg_data
);

	chip8_pkg::instr_t instr_q;
	logic [3:0] rd_addr_a, rd_addr_b;
	logic [chip8_pkg::DATA_W-1:0] rd_data_a, rd_data_b;
	logic [chip8_pkg::DATA_W-1:0] alu_a, alu_b, alu_res;
	chip8_pkg::alu_op_e alu_op;
	logic alu_flag;
	chip8_pkg::reg_wr_t wr_res, wr_flag;
	chip8_pkg::i_wr_t i_wr;
	chip8_pkg::pc_cmd_t pc_cmd;

	// Busy is high for exactly the execute cycle
	always_ff @(posedge cpu_clk) begin
		if (!rst_n)
			busy <= 1'b0;
		else if (busy)
			busy <= 1'b0;
		else if (instr_strobe)
			busy <= 1'b1;
	end

	// Latch only on an accepted strobe
	always_ff @(posedge cpu_clk) begin
		if (!busy && instr_strobe)
			instr_q <= instr;
	end

	always_ff @(posedge cpu_clk) begin
		if (!rst_n)
			i_reg <= '0;
		else if (i_wr.we)
			i_reg <= i_wr.value;
	end

	chip8_decode decode_i (
		.exec(busy), .ins(instr_q),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.i_cur(i_reg),
		.alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op),
		.alu_res(alu_res), .alu_flag(alu_flag),
		.wr_res(wr_res), .wr_flag(wr_flag),
		.i_wr(i_wr), .pc_cmd(pc_cmd)
	);

	chip8_alu alu_i (.a(alu_a), .b(alu_b), .op(alu_op), .res(alu_res), .flag(alu_flag));

	reg_file regs_i (
		.cpu_clk(cpu_clk), .rst_n(rst_n),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.host_addr(host_reg_addr), .host_data(host_reg_data),
		.wr_res(wr_res), .wr_flag(wr_flag)
	);

	pc_unit #(.STACK_DEPTH(STACK_DEPTH)) pc_i (
		.cpu_clk(cpu_clk), .rst_n(rst_n),
		.exec(busy), .pc_cmd(pc_cmd), .pc(pc)
	);

endmodule

// ==== src/reg_file.sv ====
// Sixteen V registers, two combinational reads plus a host read port
// Flag port wins over the result port on the same index
`timescale 1ns/1ps

module reg_file (
	input logic cpu_clk,
	input logic rst_n,
	input logic [3:0] rd_addr_a,
	input logic [3:0] rd_addr_b,
	output logic [chip8_pkg::DATA_W-1:0] rd_data_a,
	output logic [chip8_pkg::DATA_W-1:0] rd_data_b,
	input logic [3:0] host_addr,
	output logic [chip8_pkg::DATA_W-1:0] host_data,
	input chip8_pkg::reg_wr_t wr_res,
	input chip8_pkg::reg_wr_t wr_flag
);

	logic [chip8_pkg::DATA_W-1:0] v [chip8_pkg::REG_CNT];

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < chip8_pkg::REG_CNT; i++)
				v[i] <= '0;
		end else begin
			if (wr_res.we)
				v[wr_res.idx] <= wr_res.data;
			// Later assignment gives the flag port priority
			if (wr_flag.we)
				v[wr_flag.idx] <= wr_flag.data;
		end
	end

	assign rd_data_a = v[rd_addr_a];
	assign rd_data_b = v[rd_addr_b];
	assign host_data = v[host_addr];

endmodule

// ==== tb.f ====
+incdir+test
common/chip8_pkg.sv
exec/chip8_alu.sv
exec/chip8_decode.sv
src/reg_file.sv
pc/call_stack.sv
pc/pc_unit.sv
src/chip8_core.sv
test/tb_chip8.sv

// ==== test/chip8_model.svh ====
// Architectural model of the CHIP-8 core state, included inside the testbench module
// Needs STACK_DEPTH declared before the include, stack pointer wraps modulo that depth
`ifndef CHIP8_MODEL_SVH
`define CHIP8_MODEL_SVH

logic [7:0] m_v [16];
logic [11:0] m_i;
logic [11:0] m_pc;
logic [11:0] m_stack [STACK_DEPTH];
int m_sp;

task automatic reset_model();
	for (int k = 0; k < 16; k++)
		m_v[k] = 8'h00;
	m_i = 12'h000;
	m_pc = 12'h200;
	m_sp = 0;
endtask

// Applies one instruction word to the model state
task automatic apply_model(input logic [15:0] w);
	logic [3:0] x;
	logic [3:0] y;
	logic [3:0] n;
	logic [7:0] kk;
	logic [7:0] vx;
	logic [7:0] vy;
	logic [7:0] res;
	logic [8:0] wide;
	logic [11:0] nnn;
	logic [11:0] next_pc;
	logic has_res;
	logic has_flag;
	logic flag;
	x = w[11:8];
	y = w[7:4];
	n = w[3:0];
	kk = w[7:0];
	nnn = w[11:0];
	vx = m_v[x];
	vy = m_v[y];
	next_pc = m_pc + 12'd2;
	has_res = 1'b1;
	has_flag = 1'b1;
	res = vx;
	flag = 1'b0;
	case (w[15:12])
		4'h0: begin
			if (w == 16'h00EE) begin
				m_sp = (m_sp + STACK_DEPTH - 1) % STACK_DEPTH;
				next_pc = m_stack[m_sp];
			end
		end
		4'h1: next_pc = nnn;
		4'h2: begin
			m_stack[m_sp] = m_pc + 12'd2;
			m_sp = (m_sp + 1) % STACK_DEPTH;
			next_pc = nnn;
		end
		4'h3: if (vx == kk) next_pc = m_pc + 12'd4;
		4'h4: if (vx != kk) next_pc = m_pc + 12'd4;
		4'h5: if (n == 4'h0 && vx == vy) next_pc = m_pc + 12'd4;
		4'h6: m_v[x] = kk;
		4'h7: m_v[x] = vx + kk;
		4'h8: begin
			case (n)
				4'h0: begin
					res = vy;
					has_flag = 1'b0;
				end
				4'h1: begin
					res = vx | vy;
					has_flag = 1'b0;
				end
				4'h2: begin
					res = vx & vy;
					has_flag = 1'b0;
				end
				4'h3: begin
					res = vx ^ vy;
					has_flag = 1'b0;
				end
				4'h4: begin
					wide = {1'b0, vx} + {1'b0, vy};
					res = wide[7:0];
					flag = wide[8];
				end
				4'h5: begin
					res = vx - vy;
					flag = (vx >= vy);
				end
				4'h6: begin
					res = vx >> 1;
					flag = vx[0];
				end
				4'h7: begin
					res = vy - vx;
					flag = (vy >= vx);
				end
				4'hE: begin
					res = vx << 1;
					flag = vx[7];
				end
				default: begin
					has_res = 1'b0;
					has_flag = 1'b0;
				end
			endcase
			if (has_res)
				m_v[x] = res;
			// VF written last so it wins when x is F
			if (has_flag)
				m_v[15] = {7'b0, flag};
		end
		4'h9: if (n == 4'h0 && vx != vy) next_pc = m_pc + 12'd4;
		4'hA: m_i = nnn;
		4'hB: next_pc = nnn + {4'h0, m_v[0]};
		4'hF: begin
			if (kk == 8'h1E)
				m_i = m_i + {4'h0, vx};
			else if (kk == 8'h29)
				m_i = 12'(vx[3:0]) * 12'd5;
		end
		default: ;
	endcase
	m_pc = next_pc;
endtask

`endif

// ==== test/tb_chip8.sv ====
// Random-stimulus testbench for the CHIP-8 core, every result checked against the model
// Returns are only issued after the nested call test has written every stack entry
`timescale 1ns/1ps

module tb_chip8;

	localparam int STACK_DEPTH = chip8_pkg::STACK_DEPTH;
	localparam int CLK_PERIOD = 100;
	localparam int N_ALU = 300;
	localparam int N_SKIP = 150;
	localparam int N_BUSY = 10;
	localparam int N_JUMP = 40;
	localparam int N_CALL = STACK_DEPTH + 3;
	localparam int N_ILOAD = 150;
	localparam int N_MIX = 2000;
	localparam int N_INSTR = 16 + N_ALU + N_SKIP + N_BUSY + N_JUMP + 2 * N_CALL + N_ILOAD
		+ N_MIX + N_MIX / 4;
	// Four cycles per instruction plus reset and some margin
	localparam longint WATCHDOG = longint'(N_INSTR * 4 + 8 + 4) * CLK_PERIOD;

	logic cpu_clk;
	logic rst_n;
	logic instr_strobe;
	chip8_pkg::instr_t instr;
	logic busy;
	logic [11:0] pc;
	logic [11:0] i_reg;
	logic [3:0] host_reg_addr;
	logic [7:0] host_reg_data;
	logic [31:0] seed;
	string test_name;

	`include "chip8_model.svh"

	chip8_core #(.STACK_DEPTH(STACK_DEPTH)) dut_i (
		.cpu_clk(cpu_clk), .rst_n(rst_n),
		.instr_strobe(instr_strobe), .instr(instr), .busy(busy),
		.pc(pc), .i_reg(i_reg),
		.host_reg_addr(host_reg_addr), .host_reg_data(host_reg_data)
	);

	always #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;

	// LCG step, upper half is the better-mixed part
	function automatic logic [15:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	task automatic expect_equal(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Value mismatch on %s", what);
		end
	endtask

	// PC, I, busy and all V registers through the host port
	task automatic compare_state();
		expect_equal("pc", m_pc, pc);
		expect_equal("i_reg", m_i, i_reg);
		expect_equal("busy", 0, busy);
		for (int k = 0; k < 16; k++) begin
			host_reg_addr = 4'(k);
			#1;
			expect_equal($sformatf("v%0h", k), m_v[k], host_reg_data);
		end
		// Back on a falling edge for the next strobe
		@(negedge cpu_clk);
	endtask

	// Called at a falling edge with busy low
	// With extra set the strobe stays high through the busy cycle with another word
	task automatic issue(input logic [15:0] w, input logic extra, input logic [15:0] other);
		instr_strobe = 1'b1;
		instr = w;
		@(negedge cpu_clk);
		expect_equal("busy after strobe", 1, busy);
		if (extra)
			instr = other;
		else
			instr_strobe = 1'b0;
		// Execute commits on the next edge, busy drops with it
		@(negedge cpu_clk);
		instr_strobe = 1'b0;
		apply_model(w);
		compare_state();
	endtask

	// Classes: 0 loads and ALU, 1 skips, 2 jumps, 3 I loads, 4 unkept, 5 call, 6 return
	function automatic logic [15:0] make_opcode(input int cls);
		logic [15:0] r;
		logic [15:0] s;
		logic [3:0] x;
		logic [3:0] y;
		logic [3:0] n;
		logic [7:0] kk;
		logic [15:0] w;
		r = lcg_next();
		s = lcg_next();
		x = r[11:8];
		y = r[7:4];
		kk = r[7:0];
		n = s[3:0];
		case (cls)
			0: begin
				// Every eighth one targets VF
				if (s[10:8] == 3'd0)
					x = 4'hF;
				if (n > 4'h8)
					n = n - 4'h9;
				if (n == 4'h8)
					n = 4'hE;
				if (s[7:5] == 3'd0)
					w = {4'h6, x, kk};
				else if (s[7:5] == 3'd1)
					w = {4'h7, x, kk};
				else
					w = {4'h8, x, y, n};
			end
			1: begin
				// Bias toward conditions that hold
				if (s[2])
					kk = m_v[x];
				if (s[3])
					y = x;
				case (s[1:0])
					2'd0: w = {4'h3, x, kk};
					2'd1: w = {4'h4, x, kk};
					2'd2: w = {4'h5, x, y, 4'h0};
					default: w = {4'h9, x, y, 4'h0};
				endcase
			end
			2: w = s[0] ? {4'h1, r[11:0]} : {4'hB, r[11:0]};
			3: begin
				case (s[1:0])
					2'd0: w = {4'hA, r[11:0]};
					2'd1: w = {4'hF, x, 8'h29};
					default: w = {4'hF, x, 8'h1E};
				endcase
			end
			4: begin
				n = {1'b1, s[5:3]};
				if (n == 4'hE)
					n = 4'hF;
				if (kk == 8'h1E || kk == 8'h29)
					kk = 8'h07;
				case (s[2:0])
					3'd0: w = {4'h0, r[11:0]};
					3'd1: w = {4'hC, r[11:0]};
					3'd2: w = {4'hD, r[11:0]};
					3'd3: w = {4'hE, r[11:0]};
					3'd4: w = {4'hF, x, kk};
					3'd5: w = {4'h8, x, y, n};
					default: w = {s[6] ? 4'h5 : 4'h9, x, y, 4'h1 | s[10:7]};
				endcase
			end
			5: w = {4'h2, r[11:0]};
			default: w = 16'h00EE;
		endcase
		return w;
	endfunction

	initial begin
		#(WATCHDOG);
		$display("Timeout: the DUT did not finish all instructions in %0d ns", WATCHDOG);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		int c;
		logic [15:0] r;
		cpu_clk = 1'b0;
		rst_n = 1'b0;
		instr_strobe = 1'b0;
		instr = '0;
		host_reg_addr = 4'h0;
		seed = 32'hfc5f_be75;
		reset_model();
		repeat (8)
			@(negedge cpu_clk);
		rst_n = 1'b1;
		test_name = "reset";
		compare_state();

		// Random values into every register first
		test_name = "alu";
		for (int k = 0; k < 16; k++) begin
			r = lcg_next();
			issue({4'h6, 4'(k), r[7:0]}, 1'b0, 16'h0);
		end
		for (int k = 0; k < N_ALU; k++)
			issue(make_opcode(0), 1'b0, 16'h0);

		test_name = "skip";
		for (int k = 0; k < N_SKIP; k++)
			issue(make_opcode(1), 1'b0, 16'h0);
		test_name = "strobe while busy";
		for (int k = 0; k < N_BUSY; k++)
			issue(make_opcode(1), 1'b1, make_opcode(0));

		test_name = "jump";
		for (int k = 0; k < N_JUMP; k++)
			issue(make_opcode(2), 1'b0, 16'h0);
		// Deeper than the stack so the pointer wraps both ways
		test_name = "call";
		for (int k = 0; k < N_CALL; k++)
			issue(make_opcode(5), 1'b0, 16'h0);
		test_name = "return";
		for (int k = 0; k < N_CALL; k++)
			issue(16'h00EE, 1'b0, 16'h0);

		test_name = "i load";
		for (int k = 0; k < N_ILOAD; k++)
			issue(make_opcode(3), 1'b0, 16'h0);

		test_name = "mix";
		for (int k = 0; k < N_MIX; k++) begin
			c = lcg_next() % 10;
			if (c < 4)
				c = 0;
			else if (c < 6)
				c = 1;
			else if (c == 6)
				c = 2;
			else if (c == 7)
				c = 3;
			else if (c == 8)
				c = 5;
			else
				c = 6;
			issue(make_opcode(c), 1'b0, 16'h0);
			if (k % 4 == 0)
				issue(make_opcode(4), 1'b0, 16'h0);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
